// File: Bender.yml
package:
  name: prg

sources:
  - files:
      - design/prg_pkg.sv
      - design/tile_scanner.sv
      - design/ray_dir_pipe.sv
      - design/valid_stall_pipe.sv
      - design/ray_fifo.sv
      - design/prg.sv
  - target: test
    files:
      - tests/prg_tb.sv

// File: design/prg.sv
module prg import prg_pkg::*; #(
	parameter int pipe_depth = 4
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic gen_en,
	input logic [5:0] keys,
	input vector_t eye,
	input vector_t u,
	input vector_t v,
	input vector_t w,
	input logic shader_stall,
	output logic shader_valid,
	output ray_t shader_ray
);

	logic issue;
	logic credit_stall;
	coord_t coord;
	pixel_id_t pixel_id;
	vector_t dir;
	logic out_valid;
	pixel_id_t out_pixel_id;
	ray_t fifo_wdata;
	logic fifo_empty;
	logic fifo_rd;
	logic [4:0] fifo_used;

	tile_scanner scanner_i (
		.clk,
		.rst,
		.start,
		.gen_en,
		.keys,
		.credit_stall,
		.issue,
		.coord,
		.pixel_id
	);

	ray_dir_pipe #(.pipe_depth(pipe_depth)) dir_pipe_i (
		.clk,
		.rst,
		.coord,
		.u,
		.v,
		.w,
		.dir
	);

	valid_stall_pipe #(.pipe_depth(pipe_depth)) valid_pipe_i (
		.clk,
		.rst,
		.issue,
		.pixel_id,
		.used(fifo_used),
		.out_valid,
		.out_pixel_id,
		.credit_stall
	);

	// every ray starts at the eye
	assign fifo_wdata = '{origin: eye, dir: dir, pixel_id: out_pixel_id};

	assign shader_valid = ~fifo_empty;
	assign fifo_rd = shader_valid && !shader_stall;

	ray_fifo fifo_i (
		.clk,
		.rst,
		.wr(out_valid),
		.wdata(fifo_wdata),
		.rd(fifo_rd),
		.rdata(shader_ray),
		.empty(fifo_empty),
		.used(fifo_used)
	);

endmodule

// File: design/prg_pkg.sv
package prg_pkg;

	// one box of the frame walk
	localparam int box_cols = 20;
	localparam int box_rows = 15;

	localparam int max_scale = 5;
	localparam int reset_scale = 0;

	// sized for the largest frame, 640 x 480
	typedef logic [9:0] col_t;
	typedef logic [8:0] row_t;
	typedef logic [18:0] pixel_id_t;
	typedef logic [2:0] scale_t;

	// signed 8.8 fixed point
	typedef logic signed [15:0] fix_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vector_t;

	typedef struct packed {
		vector_t origin;
		vector_t dir;
		pixel_id_t pixel_id;
	} ray_t;

	// work item for the direction pipe
	typedef struct packed {
		col_t col;
		row_t row;
		scale_t scale;
	} coord_t;

	function automatic col_t frame_cols(scale_t s);
		return col_t'(box_cols << s);
	endfunction

	function automatic row_t frame_rows(scale_t s);
		return row_t'(box_rows << s);
	endfunction

endpackage

// File: design/ray_dir_pipe.sv
module ray_dir_pipe import prg_pkg::*; #(
	parameter int pipe_depth = 4
) (
	input logic clk,
	input logic rst,
	input coord_t coord,
	input vector_t u,
	input vector_t v,
	input vector_t w,
	output vector_t dir
);

	logic signed [10:0] dx_d;
	logic signed [9:0] dy_d;
	logic signed [10:0] dx_q;
	logic signed [9:0] dy_q;
	scale_t scale_q1;
	scale_t scale_q2;

	fix_t uc [3];
	fix_t vc [3];
	fix_t wc [3];
	logic signed [31:0] prod_q [3];
	vector_t sum3;

	assign uc = '{u.x, u.y, u.z};
	assign vc = '{v.x, v.y, v.z};
	assign wc = '{w.x, w.y, w.z};

	// center on the middle of the frame
	assign dx_d = signed'({1'b0, coord.col}) - signed'({1'b0, frame_cols(coord.scale) >> 1});
	assign dy_d = signed'({1'b0, coord.row}) - signed'({1'b0, frame_rows(coord.scale) >> 1});

	always_ff @(posedge clk) begin
		dx_q <= dx_d;
		dy_q <= dy_d;
		scale_q1 <= coord.scale;
	end

	// products sign-extend to 32 bits
	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			prod_q[i] <= dx_q * uc[i] + dy_q * vc[i];
		end
		scale_q2 <= scale_q1;
	end

	// scale down to one step per pixel and add the view center
	assign sum3 = '{
		x: wc[0] + fix_t'(prod_q[0] >>> scale_q2),
		y: wc[1] + fix_t'(prod_q[1] >>> scale_q2),
		z: wc[2] + fix_t'(prod_q[2] >>> scale_q2)
	};

	generate
		if (pipe_depth > 2) begin : g_delay
			vector_t dly [pipe_depth-2];

			always_ff @(posedge clk) begin
				dly[0] <= sum3;
				for (int i = 1; i < pipe_depth - 2; i++) begin
					dly[i] <= dly[i-1];
				end
			end

			assign dir = dly[pipe_depth-3];
		end else begin : g_direct
			assign dir = sum3;
		end
	endgenerate

	scale_in_range: assert property (@(posedge clk) disable iff (rst)
		coord.scale <= scale_t'(max_scale));

endmodule

// File: design/ray_fifo.sv
module ray_fifo import prg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic wr,
	input ray_t wdata,
	input logic rd,
	output ray_t rdata,
	output logic empty,
	output logic [4:0] used
);

	localparam int depth = 16;

	ray_t mem [depth];
	logic [3:0] wr_ptr;
	logic [3:0] rd_ptr;
	logic [4:0] count;

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 4'd1;
			if (rd)
				rd_ptr <= rd_ptr + 4'd1;
			case ({wr, rd})
				2'b10: count <= count + 5'd1;
				2'b01: count <= count - 5'd1;
				default: ;
			endcase
		end
	end

	// head entry shows without a read
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);
	assign used = count;

	no_overflow: assert property (@(posedge clk) disable iff (rst)
		wr |-> count != 5'(depth));

	no_underflow: assert property (@(posedge clk) disable iff (rst)
		rd |-> !empty);

endmodule

// File: design/tile_scanner.sv
module tile_scanner import prg_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input logic gen_en,
	input logic [5:0] keys,
	input logic credit_stall,
	output logic issue,
	output coord_t coord,
	output pixel_id_t pixel_id
);

	typedef enum logic {
		st_idle,
		st_active
	} state_t;

	state_t state;
	scale_t scale;
	scale_t scale_d;
	logic scale_ld;

	// position inside the current box
	logic [4:0] x;
	logic [3:0] y;

	// Morton box counter and the last box of the frame
	logic [9:0] cr;
	logic [9:0] last_cr;

	logic [4:0] box_col;
	logic [4:0] box_row;
	logic [4:0] max_box_row;
	col_t col;
	col_t cols;
	row_t row;
	row_t rows;
	logic box_done;
	logic frame_done;

	// keys[i] picks scale i, anything not one-hot gives the largest scale
	always_comb begin
		case (keys)
			6'b000001: scale_d = 3'd0;
			6'b000010: scale_d = 3'd1;
			6'b000100: scale_d = 3'd2;
			6'b001000: scale_d = 3'd3;
			6'b010000: scale_d = 3'd4;
			6'b100000: scale_d = 3'd5;
			default: scale_d = scale_t'(max_scale);
		endcase
	end

	assign scale_ld = (|keys) && (state == st_idle);

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			scale <= scale_t'(reset_scale);
		else if (scale_ld)
			scale <= scale_d;
	end

	assign issue = (state == st_active) && gen_en && !credit_stall;

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			state <= st_idle;
		else if (state == st_idle && start)
			state <= st_active;
		else if (issue && frame_done)
			state <= st_idle;
	end

	// the last pixel wraps x, y and cr back to their start values
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			x <= '0;
			y <= 4'(box_rows - 1);
			cr <= '0;
		end else if (issue) begin
			if (x == 5'(box_cols - 1)) begin
				x <= '0;
				y <= (y == '0) ? 4'(box_rows - 1) : y - 4'd1;
			end else begin
				x <= x + 5'd1;
			end
			if (box_done)
				cr <= frame_done ? '0 : cr + 10'd1;
		end
	end

	assign box_done = (x == 5'(box_cols - 1)) && (y == '0);
	assign last_cr = 10'((11'd1 << {scale, 1'b0}) - 11'd1);
	assign frame_done = box_done && (cr == last_cr);

	// even bits give the box column, odd bits the box row
	assign box_col = {cr[8], cr[6], cr[4], cr[2], cr[0]};
	assign box_row = {cr[9], cr[7], cr[5], cr[3], cr[1]};
	assign max_box_row = 5'((6'd1 << scale) - 6'd1);

	assign cols = frame_cols(scale);
	assign rows = frame_rows(scale);

	// box row 0 sits at the top of the frame
	assign col = col_t'(box_cols) * col_t'(box_col) + col_t'(x);
	assign row = row_t'(box_rows) * row_t'(max_box_row - box_row) + row_t'(y);

	assign pixel_id = (pixel_id_t'(rows) - pixel_id_t'(row) - 19'd1) * pixel_id_t'(cols)
		+ pixel_id_t'(col);

	assign coord = '{col: col, row: row, scale: scale};

	// outside a frame the counters rest at the first pixel
	idle_at_frame_start: assert property (@(posedge clk) disable iff (rst)
		state == st_idle |-> x == '0 && y == 4'(box_rows - 1) && cr == '0);

	scale_held: assert property (@(posedge clk) disable iff (rst)
		state == st_active |=> $stable(scale));

endmodule

// File: design/valid_stall_pipe.sv
module valid_stall_pipe import prg_pkg::*; #(
	parameter int pipe_depth = 4
) (
	input logic clk,
	input logic rst,
	input logic issue,
	input pixel_id_t pixel_id,
	input logic [4:0] used,
	output logic out_valid,
	output pixel_id_t out_pixel_id,
	output logic credit_stall
);

	logic [pipe_depth-1:0] valid_q;
	pixel_id_t id_q [pipe_depth];
	logic [4:0] in_flight;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			valid_q <= '0;
			for (int i = 0; i < pipe_depth; i++) begin
				id_q[i] <= '0;
			end
		end else begin
			valid_q <= {valid_q[pipe_depth-2:0], issue};
			id_q[0] <= pixel_id;
			for (int i = 1; i < pipe_depth; i++) begin
				id_q[i] <= id_q[i-1];
			end
		end
	end

	assign out_valid = valid_q[pipe_depth-1];
	assign out_pixel_id = id_q[pipe_depth-1];

	// rays issued but not yet written to the FIFO
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			in_flight <= '0;
		else
			in_flight <= in_flight + 5'(issue) - 5'(out_valid);
	end

	// reads are not counted, so the credit is conservative
	assign credit_stall = in_flight >= (5'd16 - used);

	no_write_into_full: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> used != 5'd16);

endmodule

// File: prg.f
design/prg_pkg.sv
design/tile_scanner.sv
design/ray_dir_pipe.sv
design/valid_stall_pipe.sv
design/ray_fifo.sv
design/prg.sv
tests/prg_tb.sv

// File: tests/prg_tb.sv
module prg_tb import prg_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int pipe_depth = 4;
	// rays over all frames of all tests
	localparam int total_rays = 10500;
	localparam int timeout_cycles = 40 * total_rays + 2000;

	logic clk, rst, start, gen_en, shader_stall, shader_valid;
	logic [5:0] keys;
	vector_t eye, u, v, w;
	ray_t shader_ray;

	logic [31:0] lcg_state;
	logic stall_random, stall_level, gen_random;
	int gen_low_left;
	ray_t got_q[$];
	ray_t exp_q[$];

	prg #(.pipe_depth(pipe_depth)) dut_i (
		.clk, .rst, .start, .gen_en, .keys, .eye, .u, .v, .w,
		.shader_stall, .shader_valid, .shader_ray
	);

	always #2 clk = ~clk;

	// a ray leaves the FIFO at the edge after this sample
	always @(negedge clk) begin
		if (!rst && shader_valid && !shader_stall)
			got_q.push_back(shader_ray);
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("simulation timed out before all rays arrived");
		$display("Test FAILED");
		$fatal(1);
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic vector_t random_vector();
		vector_t r;
		r.x = fix_t'(lcg_next() >> 16);
		r.y = fix_t'(lcg_next() >> 16);
		r.z = fix_t'(lcg_next() >> 16);
		return r;
	endfunction

	function automatic fix_t dir_component(int dx, int dy, fix_t uc, fix_t vc, fix_t wc, int s);
		int sum;
		sum = dx * uc + dy * vc;
		sum = sum >>> s;
		return wc + fix_t'(sum);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// one clock, then drive the random or held levels
	task automatic step();
		logic [31:0] r;
		@(posedge clk);
		#1;
		r = lcg_next();
		shader_stall = stall_random ? r[16] : stall_level;
		if (!gen_random) begin
			gen_en = 1'b1;
		end else if (gen_low_left > 0) begin
			gen_en = 1'b0;
			gen_low_left--;
		end else if (r[27:24] == 4'd0) begin
			gen_en = 1'b0;
			gen_low_left = int'(r[30:28]);
		end else begin
			gen_en = 1'b1;
		end
	endtask

	task automatic pulse_start();
		step();
		start = 1'b1;
		step();
		start = 1'b0;
	endtask

	// key n selects scale n-1
	task automatic press_key(input int n);
		step();
		keys = 6'(1 << (n - 1));
		step();
		keys = '0;
	endtask

	task automatic set_view();
		eye = random_vector();
		u = random_vector();
		v = random_vector();
		w = random_vector();
	endtask

	// boxes in Morton order, rows top down, columns left to right
	task automatic expect_frame(input int s);
		int cols, rows, b, k, bc, br, x, y, col, row, dx, dy;
		ray_t r;
		cols = 20 << s;
		rows = 15 << s;
		for (b = 0; b < (1 << (2 * s)); b++) begin
			bc = 0;
			br = 0;
			for (k = 0; k < 5; k++) begin
				bc = bc | (((b >> (2 * k)) & 1) << k);
				br = br | (((b >> (2 * k + 1)) & 1) << k);
			end
			for (y = 14; y >= 0; y--) begin
				for (x = 0; x < 20; x++) begin
					col = 20 * bc + x;
					row = 15 * ((1 << s) - 1 - br) + y;
					dx = col - cols / 2;
					dy = row - rows / 2;
					r.origin = eye;
					r.dir.x = dir_component(dx, dy, u.x, v.x, w.x, s);
					r.dir.y = dir_component(dx, dy, u.y, v.y, w.y, s);
					r.dir.z = dir_component(dx, dy, u.z, v.z, w.z, s);
					r.pixel_id = pixel_id_t'((rows - 1 - row) * cols + col);
					exp_q.push_back(r);
				end
			end
		end
	endtask

	task automatic compare_frame();
		int i;
		assert (got_q.size() == exp_q.size()) else
			abort_run($sformatf("mismatch shader_ray count: got %h expected %h",
				got_q.size(), exp_q.size()));
		for (i = 0; i < exp_q.size(); i++) begin
			assert (got_q[i].origin == exp_q[i].origin) else
				abort_run($sformatf("mismatch shader_ray.origin ray %0d: got %h expected %h",
					i, got_q[i].origin, exp_q[i].origin));
			assert (got_q[i].dir == exp_q[i].dir) else
				abort_run($sformatf("mismatch shader_ray.dir ray %0d: got %h expected %h",
					i, got_q[i].dir, exp_q[i].dir));
			assert (got_q[i].pixel_id == exp_q[i].pixel_id) else
				abort_run($sformatf("mismatch shader_ray.pixel_id ray %0d: got %h expected %h",
					i, got_q[i].pixel_id, exp_q[i].pixel_id));
		end
		got_q.delete();
		exp_q.delete();
	endtask

	// extra cycles catch duplicated or trailing rays
	task automatic collect_frame();
		while (got_q.size() < exp_q.size())
			step();
		repeat (4 * pipe_depth + 20) step();
		compare_frame();
	endtask

	task automatic idle_quiet_test();
		int i;
		for (i = 0; i < 50; i++) begin
			step();
			keys = (i < 20) ? 6'b000100 : ((i < 35) ? 6'b101000 : 6'b000000);
			assert (!shader_valid) else
				abort_run($sformatf("mismatch shader_valid: got %h expected %h",
					shader_valid, 1'b0));
		end
		press_key(1);
	endtask

	task automatic scale0_frame_test();
		set_view();
		expect_frame(0);
		pulse_start();
		collect_frame();
	endtask

	task automatic scale_select_test();
		press_key(2);
		set_view();
		expect_frame(1);
		pulse_start();
		press_key(5);
		collect_frame();
		set_view();
		expect_frame(1);
		pulse_start();
		collect_frame();
		press_key(3);
		set_view();
		expect_frame(2);
		pulse_start();
		collect_frame();
	endtask

	task automatic stall_test();
		int held;
		int i;
		press_key(2);
		set_view();
		stall_random = 1'b1;
		expect_frame(1);
		pulse_start();
		collect_frame();
		set_view();
		expect_frame(1);
		pulse_start();
		while (got_q.size() < 100)
			step();
		stall_random = 1'b0;
		stall_level = 1'b1;
		step();
		held = got_q.size();
		// the head must stay the next ray in order while the shader holds
		for (i = 0; i < 200; i++) begin
			step();
			if (shader_valid) begin
				assert (shader_ray == exp_q[held]) else
					abort_run($sformatf(
						"mismatch shader_ray head under stall: got %h expected %h",
						shader_ray, exp_q[held]));
			end
		end
		assert (dut_i.fifo_i.used == 5'd16) else
			abort_run($sformatf("mismatch fifo used: got %h expected %h",
				dut_i.fifo_i.used, 5'd16));
		stall_level = 1'b0;
		collect_frame();
	endtask

	task automatic gen_pause_test();
		press_key(1);
		set_view();
		gen_random = 1'b1;
		expect_frame(0);
		pulse_start();
		collect_frame();
		gen_random = 1'b0;
	endtask

	task automatic double_start_test();
		int i;
		set_view();
		expect_frame(0);
		pulse_start();
		repeat (10) step();
		pulse_start();
		collect_frame();
		for (i = 0; i < 100; i++) begin
			step();
			assert (!shader_valid) else
				abort_run($sformatf("mismatch shader_valid: got %h expected %h",
					shader_valid, 1'b0));
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		gen_en = 1'b0;
		keys = '0;
		eye = '0;
		u = '0;
		v = '0;
		w = '0;
		shader_stall = 1'b0;
		lcg_state = 32'h82664746;
		stall_random = 1'b0;
		stall_level = 1'b0;
		gen_random = 1'b0;
		gen_low_left = 0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		idle_quiet_test();
		scale0_frame_test();
		scale_select_test();
		stall_test();
		gen_pause_test();
		double_start_test();
		$display("Test OK");
		$finish;
	end

endmodule
